//--- logic/rename_pkg.sv
package rename_pkg;

    // architectural register file size.
    localparam int ARCH_REGS = 32;

    // physical register width the shared structs are declared at.
    localparam int DEFAULT_PHYS_REG_BITS = 6;

    typedef logic [4:0] arch_reg_t;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_b_imm = 7'b0010011,
        op_b_reg = 7'b0110011
    } opcode_t;

    // the rs2 slot is a register in R-type and immediate bits in I-type.
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            arch_reg_t  rs2;
            arch_reg_t  rs1;
            logic [2:0] funct3;
            arch_reg_t  rd;
            opcode_t    opcode;
        } r_fields;
        struct packed {
            logic [11:0] imm;
            arch_reg_t   rs1;
            logic [2:0]  funct3;
            arch_reg_t   rd;
            opcode_t     opcode;
        } i_fields;
    } inst_word_t;

    typedef struct packed {
        inst_word_t inst;
        opcode_t    opcode;
        arch_reg_t  rd;
        arch_reg_t  rs1;
        arch_reg_t  rs2;
        logic       rename;
        logic       is_nop;
    } decode_info_t;

    // one result bus.
    typedef struct packed {
        logic                             valid;
        arch_reg_t                        rd;
        logic [DEFAULT_PHYS_REG_BITS-1:0] pd;
    } cdb_t;

    typedef struct packed {
        logic [DEFAULT_PHYS_REG_BITS-1:0] ps1;
        logic                             ps1_valid;
        logic [DEFAULT_PHYS_REG_BITS-1:0] ps2;
        logic                             ps2_valid;
        logic [DEFAULT_PHYS_REG_BITS-1:0] pd;
        logic [DEFAULT_PHYS_REG_BITS-1:0] stale_pd;
        logic                             has_rd;
    } renamed_t;

endpackage

//--- logic/inst_decode.sv
`timescale 1ns/100ps

module inst_decode (
    input  rename_pkg::inst_word_t   inst,
    output rename_pkg::decode_info_t info
);

    import rename_pkg::*;

    logic writes_rd;

    // opcodes that produce a register result.
    always_comb begin
        case (inst.i_fields.opcode)
            op_lui,
            op_auipc,
            op_jal,
            op_jalr,
            op_load,
            op_b_imm,
            op_b_reg: writes_rd = 1'b1;
            default:  writes_rd = 1'b0;
        endcase
    end

    always_comb begin
        info.inst   = inst;
        info.opcode = inst.i_fields.opcode;
        info.rd     = inst.i_fields.rd;
        info.rs1    = inst.i_fields.rs1;
        // only meaningful as a register for R-type and store/branch.
        info.rs2    = inst.r_fields.rs2;

        // x0 is never renamed.
        info.rename = writes_rd && (inst.i_fields.rd != 5'd0);

        // canonical nop and the all-zero word.
        info.is_nop = (inst == 32'h0000_0013) || (inst == 32'h0000_0000);
    end

endmodule

//--- logic/free_list.sv
`timescale 1ns/100ps

module free_list #(
    parameter int PHYS_REG_BITS = 6
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     alloc,
    input  logic                     release_en,
    input  logic [PHYS_REG_BITS-1:0] release_pd,
    output logic [PHYS_REG_BITS-1:0] alloc_pd,
    output logic                     empty
);

    import rename_pkg::*;

    localparam int DEPTH    = (2 ** PHYS_REG_BITS) - ARCH_REGS;
    localparam int PTR_BITS = $clog2(DEPTH);

    logic [PHYS_REG_BITS-1:0] fifo [DEPTH];
    logic [PTR_BITS-1:0]      head;
    logic [PTR_BITS-1:0]      tail;
    logic [PTR_BITS:0]        count;
    logic [PTR_BITS-1:0]      head_inc;
    logic [PTR_BITS-1:0]      tail_inc;

    // depth need not be a power of two, so wrap by hand.
    always_comb begin
        if (head == PTR_BITS'(DEPTH - 1)) begin
            head_inc = '0;
        end else begin
            head_inc = head + 1'b1;
        end
        if (tail == PTR_BITS'(DEPTH - 1)) begin
            tail_inc = '0;
        end else begin
            tail_inc = tail + 1'b1;
        end
    end

    assign alloc_pd = fifo[head];
    assign empty    = (count == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            // every register above the architectural range starts free.
            for (int i = 0; i < DEPTH; i++) begin
                fifo[i] <= PHYS_REG_BITS'(ARCH_REGS + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= (PTR_BITS + 1)'(DEPTH);
        end else begin
            if (alloc) begin
                head <= head_inc;
            end
            if (release_en) begin
                fifo[tail] <= release_pd;
                tail       <= tail_inc;
            end
            case ({alloc, release_en})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- logic/rat.sv
`timescale 1ns/100ps

module rat #(
    parameter int PHYS_REG_BITS = 6
) (
    input  logic                     clk,
    input  logic                     rst,
    input  rename_pkg::decode_info_t info,
    input  logic                     rename_we,
    input  logic [PHYS_REG_BITS-1:0] pd,
    input  rename_pkg::cdb_t         cdb_add,
    input  rename_pkg::cdb_t         cdb_mul,
    input  rename_pkg::cdb_t         cdb_div,
    output logic [PHYS_REG_BITS-1:0] ps1,
    output logic [PHYS_REG_BITS-1:0] ps2,
    output logic [PHYS_REG_BITS-1:0] stale_pd,
    output logic                     ps1_valid,
    output logic                     ps2_valid
);

    import rename_pkg::*;

    localparam int NUM_CDB = 3;

    logic [PHYS_REG_BITS-1:0] map_q   [ARCH_REGS];
    logic                     ready_q [ARCH_REGS];
    logic                     woken   [ARCH_REGS];
    cdb_t                     cdb_bus [NUM_CDB];

    always_comb begin
        cdb_bus[0] = cdb_add;
        cdb_bus[1] = cdb_mul;
        cdb_bus[2] = cdb_div;
    end

    // a bus only wakes the entry if it still maps to the broadcast pd.
    always_comb begin
        for (int i = 0; i < ARCH_REGS; i++) begin
            woken[i] = 1'b0;
        end
        for (int b = 0; b < NUM_CDB; b++) begin
            if (cdb_bus[b].valid &&
                map_q[cdb_bus[b].rd] == PHYS_REG_BITS'(cdb_bus[b].pd)) begin
                woken[cdb_bus[b].rd] = 1'b1;
            end
        end
    end

    // lookups see the table as it stood before this edge.
    always_comb begin
        stale_pd = map_q[info.rd];
        if (info.is_nop) begin
            ps1       = '0;
            ps2       = '0;
            ps1_valid = 1'b1;
            ps2_valid = 1'b1;
        end else if (info.opcode == op_b_imm) begin
            ps1       = map_q[info.rs1];
            ps2       = map_q[info.rs1];
            ps1_valid = ready_q[info.rs1];
            ps2_valid = ready_q[info.rs1];
        end else begin
            ps1       = map_q[info.rs1];
            ps2       = map_q[info.rs2];
            ps1_valid = ready_q[info.rs1];
            ps2_valid = ready_q[info.rs2];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // identity map, all ready.
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i]   <= PHYS_REG_BITS'(i);
                ready_q[i] <= 1'b1;
            end
        end else begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                // rename takes priority over a wakeup on the same entry.
                if (rename_we && info.rd == 5'(i)) begin
                    map_q[i]   <= pd;
                    ready_q[i] <= 1'b0;
                end else if (woken[i]) begin
                    ready_q[i] <= 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/rename_unit.sv
`timescale 1ns/100ps

module rename_unit #(
    parameter int PHYS_REG_BITS = 6
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     dispatch,
    input  rename_pkg::inst_word_t   inst,
    input  logic                     commit,
    input  logic [PHYS_REG_BITS-1:0] commit_pd,
    input  rename_pkg::cdb_t         cdb_add,
    input  rename_pkg::cdb_t         cdb_mul,
    input  rename_pkg::cdb_t         cdb_div,
    output logic                     out_valid,
    output rename_pkg::renamed_t     out,
    output logic                     free_empty
);

    import rename_pkg::*;

    decode_info_t             info;
    renamed_t                 renamed;
    logic                     alloc;
    logic                     accept;
    logic                     empty;
    logic [PHYS_REG_BITS-1:0] alloc_pd;
    logic [PHYS_REG_BITS-1:0] ps1;
    logic [PHYS_REG_BITS-1:0] ps2;
    logic [PHYS_REG_BITS-1:0] stale_pd;
    logic                     ps1_valid;
    logic                     ps2_valid;

    inst_decode u_decode (
        .inst (inst),
        .info (info)
    );

    free_list #(
        .PHYS_REG_BITS (PHYS_REG_BITS)
    ) u_free_list (
        .clk        (clk),
        .rst        (rst),
        .alloc      (alloc),
        .release_en (commit),
        .release_pd (commit_pd),
        .alloc_pd   (alloc_pd),
        .empty      (empty)
    );

    rat #(
        .PHYS_REG_BITS (PHYS_REG_BITS)
    ) u_rat (
        .clk       (clk),
        .rst       (rst),
        .info      (info),
        .rename_we (alloc),
        .pd        (alloc_pd),
        .cdb_add   (cdb_add),
        .cdb_mul   (cdb_mul),
        .cdb_div   (cdb_div),
        .ps1       (ps1),
        .ps2       (ps2),
        .stale_pd  (stale_pd),
        .ps1_valid (ps1_valid),
        .ps2_valid (ps2_valid)
    );

    // a renaming dispatch with no free register is dropped.
    assign alloc      = dispatch && info.rename && !empty;
    assign accept     = dispatch && !(info.rename && empty);
    assign free_empty = empty;

    always_comb begin
        renamed.ps1       = ps1;
        renamed.ps1_valid = ps1_valid;
        renamed.ps2       = ps2;
        renamed.ps2_valid = ps2_valid;
        renamed.pd        = info.rename ? alloc_pd : '0;
        renamed.stale_pd  = info.rename ? stale_pd : '0;
        renamed.has_rd    = info.rename;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out <= renamed;
        end
    end

endmodule

//--- verification/rename_checker.sv
`timescale 1ns/100ps

module rename_checker (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         dispatch,
    input  rename_pkg::inst_word_t                       inst,
    input  logic                                         commit,
    input  logic [rename_pkg::DEFAULT_PHYS_REG_BITS-1:0] commit_pd,
    input  rename_pkg::cdb_t                             cdb_add,
    input  rename_pkg::cdb_t                             cdb_mul,
    input  rename_pkg::cdb_t                             cdb_div,
    input  logic                                         out_valid,
    input  rename_pkg::renamed_t                         out,
    input  logic                                         free_empty,
    input  int                                           test_num,
    input  logic                                         test_end,
    output logic                                         stale_avail,
    output logic [rename_pkg::DEFAULT_PHYS_REG_BITS-1:0] stale_head,
    output int                                           tests_passed,
    output int                                           tests_failed
);

    import rename_pkg::*;

    localparam int PW = DEFAULT_PHYS_REG_BITS;

    logic [PW-1:0] map_m   [ARCH_REGS];
    logic          ready_m [ARCH_REGS];
    logic          woken   [ARCH_REGS];
    logic [PW-1:0] free_q  [$];
    logic [PW-1:0] stale_q [$];
    cdb_t          buses   [3];
    renamed_t      exp_out;
    logic          pending = 1'b0;
    logic          need;
    logic          alloc;
    logic [PW-1:0] head_pd;
    int            errors = 0;
    int            passed = 0;
    int            failed = 0;

    assign tests_passed = passed;
    assign tests_failed = failed;

    function automatic string test_name(input int n);
        case (n)
            1:       return "reset_map";
            2:       return "rename_chain";
            3:       return "wakeup";
            4:       return "special_forms";
            5:       return "exhaustion_reuse";
            6:       return "random_mix";
            default: return "no_test";
        endcase
    endfunction

    // lui, auipc, jal, jalr, load, op-imm and op write rd; x0 never renames.
    function automatic logic needs_reg(input logic [31:0] w);
        logic writes;
        case (w[6:0])
            7'h37, 7'h17, 7'h6f, 7'h67, 7'h03, 7'h13, 7'h33: writes = 1'b1;
            default: writes = 1'b0;
        endcase
        return writes && (w[11:7] != 5'd0);
    endfunction

    // expected stage output from the model as it stood before the edge.
    function automatic renamed_t predict(input logic [31:0] w, input logic [PW-1:0] new_pd);
        renamed_t   r;
        logic [4:0] s1;
        logic [4:0] s2;
        s1 = w[19:15];
        // op-imm carries immediate bits in the rs2 slot.
        s2 = (w[6:0] == 7'h13) ? w[19:15] : w[24:20];
        r.has_rd   = needs_reg(w);
        r.pd       = r.has_rd ? new_pd : '0;
        r.stale_pd = r.has_rd ? map_m[w[11:7]] : '0;
        if (w == 32'h0000_0013 || w == 32'h0000_0000) begin
            r.ps1       = '0;
            r.ps2       = '0;
            r.ps1_valid = 1'b1;
            r.ps2_valid = 1'b1;
        end else begin
            r.ps1       = map_m[s1];
            r.ps2       = map_m[s2];
            r.ps1_valid = ready_m[s1];
            r.ps2_valid = ready_m[s2];
        end
        return r;
    endfunction

    task automatic reset_model();
        for (int i = 0; i < ARCH_REGS; i++) begin
            map_m[i]   = PW'(i);
            ready_m[i] = 1'b1;
        end
        free_q.delete();
        stale_q.delete();
        for (int i = ARCH_REGS; i < 2 ** PW; i++) begin
            free_q.push_back(PW'(i));
        end
        pending = 1'b0;
    endtask

    task automatic update_model();
        logic [31:0] w;
        logic [4:0]  rd;
        w  = inst;
        rd = w[11:7];
        buses[0] = cdb_add;
        buses[1] = cdb_mul;
        buses[2] = cdb_div;
        for (int i = 0; i < ARCH_REGS; i++) begin
            woken[i] = 1'b0;
        end
        for (int b = 0; b < 3; b++) begin
            if (buses[b].valid && map_m[buses[b].rd] == buses[b].pd) begin
                woken[buses[b].rd] = 1'b1;
            end
        end
        if (alloc) begin
            stale_q.push_back(map_m[rd]);
            void'(free_q.pop_front());
        end
        for (int i = 0; i < ARCH_REGS; i++) begin
            if (alloc && rd == 5'(i)) begin
                map_m[i]   = head_pd;
                ready_m[i] = 1'b0;
            end else if (woken[i]) begin
                ready_m[i] = 1'b1;
            end
        end
        if (commit) begin
            free_q.push_back(commit_pd);
            for (int k = 0; k < stale_q.size(); k++) begin
                if (stale_q[k] == commit_pd) begin
                    stale_q.delete(k);
                    break;
                end
            end
        end
    endtask

    task automatic close_test();
        if (errors == 0) begin
            passed++;
            $display("test %0d %s: passed", test_num, test_name(test_num));
        end else begin
            failed++;
            $display("test %0d %s: failed, %0d errors", test_num, test_name(test_num), errors);
        end
        errors = 0;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            reset_model();
        end else begin
            // the dispatch seen on the previous edge shows up now.
            if (pending && !out_valid) begin
                $display("%s: an accepted dispatch gave no out_valid", test_name(test_num));
                errors++;
            end else if (!pending && out_valid) begin
                $display("%s: out_valid rose with no accepted dispatch", test_name(test_num));
                errors++;
            end else if (pending && out !== exp_out) begin
                $display("ERROR %s: expected %h, actual %h", test_name(test_num), exp_out, out);
                errors++;
            end
            if (free_empty !== (free_q.size() == 0)) begin
                $display("ERROR %s free_empty: expected %b, actual %b",
                         test_name(test_num), free_q.size() == 0, free_empty);
                errors++;
            end
            need    = needs_reg(inst);
            alloc   = dispatch && need && free_q.size() != 0;
            head_pd = (free_q.size() != 0) ? free_q[0] : '0;
            pending = dispatch && !(need && free_q.size() == 0);
            if (pending) begin
                exp_out = predict(inst, head_pd);
            end
            update_model();
        end
        if (test_end) begin
            close_test();
        end
        stale_avail <= (stale_q.size() != 0);
        stale_head  <= (stale_q.size() != 0) ? stale_q[0] : '0;
    end

endmodule

//--- verification/rename_tb.sv
`timescale 1ns/100ps

module rename_tb;

    import rename_pkg::*;

    localparam int PW            = DEFAULT_PHYS_REG_BITS;
    localparam int RESET_CYCLES  = 4;
    localparam int RANDOM_CYCLES = 2000;
    // reset, drain and end strobe around each test.
    localparam int TEST_OVERHEAD = RESET_CYCLES + 5;
    localparam int RUN_CYCLES    = 40 + 6 + 10 + 6 + 42 + RANDOM_CYCLES + 6 * TEST_OVERHEAD;
    localparam int LIMIT_CYCLES  = RUN_CYCLES + RUN_CYCLES / 4;

    logic          clk;
    logic          rst;
    logic          dispatch;
    inst_word_t    inst;
    logic          commit;
    logic [PW-1:0] commit_pd;
    cdb_t          cdb_add;
    cdb_t          cdb_mul;
    cdb_t          cdb_div;
    logic          out_valid;
    renamed_t      out;
    logic          free_empty;
    int            test_num;
    logic          test_end;
    logic          stale_avail;
    logic [PW-1:0] stale_head;
    int            tests_passed;
    int            tests_failed;
    logic [31:0]   rng;
    logic          committed_last;

    rename_unit #(.PHYS_REG_BITS (PW)) dut0 (.*);

    rename_checker chk0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b0, rd, opc};
    endfunction

    function automatic cdb_t bus(input logic [4:0] rd, input logic [PW-1:0] pd);
        cdb_t b;
        b.valid = 1'b1;
        b.rd    = rd;
        b.pd    = pd;
        return b;
    endfunction

    // registers kept to x0..x7 so that sources often hit recent writes.
    function automatic logic [31:0] random_word(input logic [31:0] x);
        logic [6:0] opc;
        case (x[3:0])
            4'd0:    opc = op_lui;
            4'd1:    opc = op_auipc;
            4'd2:    opc = op_jal;
            4'd3:    opc = op_jalr;
            4'd4:    opc = op_br;
            4'd5:    opc = op_load;
            4'd6:    opc = op_store;
            4'd7:    opc = op_b_imm;
            4'd10:   return 32'h0000_0013;
            4'd11:   return 32'h0000_0000;
            default: opc = op_b_reg;
        endcase
        return {x[22:16], 2'b0, x[12:10], 2'b0, x[9:7], x[15:13], 2'b0, x[6:4], opc};
    endfunction

    // one edge of stimulus with all result buses idle.
    task automatic drive(input logic d, input logic [31:0] w, input logic c,
                         input logic [PW-1:0] cpd);
        @(posedge clk);
        dispatch  <= d;
        inst      <= w;
        commit    <= c;
        commit_pd <= cpd;
        cdb_add   <= '0;
        cdb_mul   <= '0;
        cdb_div   <= '0;
    endtask

    task automatic send(input logic [31:0] w);
        drive(1'b1, w, 1'b0, '0);
    endtask

    task automatic begin_test(input int n);
        drive(1'b0, '0, 1'b0, '0);
        rst      <= 1'b1;
        test_num <= n;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic end_test();
        drive(1'b0, '0, 1'b0, '0);
        drive(1'b0, '0, 1'b0, '0);
        @(posedge clk);
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    // a stale register is committed at most every other edge, so the
    // checker has dropped the previous one before the head is read again.
    task automatic random_cycle();
        logic [31:0] r;
        logic [31:0] w;
        logic        c;
        rng = xorshift32(rng);
        r   = rng;
        rng = xorshift32(rng);
        w   = random_word(rng);
        drive(r[0] | r[1], w, 1'b0, '0);
        c = !committed_last && stale_avail && r[2];
        commit    <= c;
        commit_pd <= stale_head;
        committed_last = c;
        if (r[3]) cdb_add <= bus({2'b0, r[10:8]}, {1'b1, r[15:11]});
        if (r[4]) cdb_mul <= bus({2'b0, r[18:16]}, {1'b1, r[23:19]});
        if (r[5]) cdb_div <= bus({2'b0, r[26:24]}, {1'b1, r[31:27]});
    endtask

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("watchdog: run did not end within %0d cycles", LIMIT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        rst            = 1'b1;
        dispatch       = 1'b0;
        inst           = '0;
        commit         = 1'b0;
        commit_pd      = '0;
        cdb_add        = '0;
        cdb_mul        = '0;
        cdb_div        = '0;
        test_num       = 0;
        test_end       = 1'b0;
        rng            = 32'h5c58_ece1;
        committed_last = 1'b0;

        begin_test(1);
        for (int r = 0; r < 32; r++) send(r_word(op_br, 5'd0, 5'(r), 5'(31 - r)));
        for (int r = 0; r < 8; r++) send(r_word(op_store, 5'(r + 1), 5'(r), 5'(r + 8)));
        end_test();

        begin_test(2);
        send(r_word(op_b_reg, 5'd1, 5'd2, 5'd3));
        send(r_word(op_b_reg, 5'd2, 5'd1, 5'd1));
        send(r_word(op_b_reg, 5'd0, 5'd1, 5'd2));
        send(r_word(op_load, 5'd1, 5'd2, 5'd4));
        send(r_word(op_lui, 5'd4, 5'd0, 5'd0));
        send(r_word(op_br, 5'd0, 5'd1, 5'd2));
        end_test();

        // x1, x2, x3 take 32, 33, 34; x3 later moves on to 35.
        begin_test(3);
        for (int k = 1; k <= 3; k++) send(r_word(op_b_reg, 5'(k), 5'd0, 5'd0));
        send(r_word(op_br, 5'd0, 5'd1, 5'd3));
        cdb_add <= bus(5'd1, 6'd32);
        cdb_mul <= bus(5'd2, 6'd33);
        cdb_div <= bus(5'd3, 6'd5);
        send(r_word(op_br, 5'd0, 5'd1, 5'd2));
        send(r_word(op_br, 5'd0, 5'd3, 5'd3));
        send(r_word(op_b_reg, 5'd3, 5'd1, 5'd2));
        cdb_div <= bus(5'd3, 6'd34);
        send(r_word(op_br, 5'd0, 5'd3, 5'd3));
        drive(1'b0, '0, 1'b0, '0);
        cdb_div <= bus(5'd3, 6'd35);
        send(r_word(op_br, 5'd0, 5'd3, 5'd0));
        end_test();

        begin_test(4);
        send(r_word(op_b_reg, 5'd7, 5'd1, 5'd2));
        send(r_word(op_b_reg, 5'd31, 5'd1, 5'd2));
        send(32'h0000_0013);
        send(32'h0000_0000);
        send(r_word(op_b_imm, 5'd5, 5'd7, 5'd31));
        send(r_word(op_b_imm, 5'd0, 5'd31, 5'd7));
        end_test();

        // x5, x9, x2 and x7 first map to themselves, so those are stale.
        begin_test(5);
        for (int i = 0; i < 32; i++) send(r_word(op_b_reg, 5'(i % 31 + 1), 5'd0, 5'd0));
        send(r_word(op_b_reg, 5'd4, 5'd0, 5'd0));
        send(r_word(op_br, 5'd0, 5'd1, 5'd2));
        drive(1'b0, '0, 1'b1, 6'd5);
        drive(1'b0, '0, 1'b1, 6'd9);
        drive(1'b0, '0, 1'b1, 6'd2);
        for (int i = 0; i < 3; i++) send(r_word(op_b_reg, 5'(10 + i), 5'd0, 5'd0));
        drive(1'b1, r_word(op_b_reg, 5'd20, 5'd0, 5'd0), 1'b1, 6'd7);
        send(r_word(op_b_reg, 5'd21, 5'd0, 5'd0));
        end_test();

        begin_test(6);
        committed_last = 1'b0;
        repeat (RANDOM_CYCLES) random_cycle();
        end_test();

        @(negedge clk);
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && tests_passed == 6) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
logic/rename_pkg.sv
logic/inst_decode.sv
logic/free_list.sv
logic/rat.sv
logic/rename_unit.sv
verification/rename_checker.sv
verification/rename_tb.sv

//--- Makefile
# Verilator build and run of the rename stage testbench.

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module rename_tb \
		-f tb.f -Mdir obj_dir -o rename_tb

run: compile
	./obj_dir/rename_tb | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
